// File: tb.f
verilog/mc_pkg.sv
verilog/mc_reset_sync.sv
verilog/mc_injector.sv
verilog/mc_tile.sv
verilog/mc_collector.sv
verilog/mc_row.sv
testbench/tb_mc_row.sv

// File: Bender.yml
package:
  name: mc_row

dependencies: {}

sources:
  # design, in compile order
  - files:
      - verilog/mc_pkg.sv
      - verilog/mc_reset_sync.sv
      - verilog/mc_injector.sv
      - verilog/mc_tile.sv
      - verilog/mc_collector.sv
      - verilog/mc_row.sv

  # testbench
  - target: test
    files:
      - testbench/tb_mc_row.sv

// File: testbench/tb_mc_row.sv
/*
  Self-checking testbench for mc_row with 4 tiles of 16 words.
  Expected responses come from a model memory per tile and a model tag counter.
*/
`timescale 1ns/100ps

module tb_mc_row;

  localparam int num_tiles_c    = 4;
  localparam int dmem_words_c   = 16;
  localparam int reset_depth_c  = 3;
  localparam int reset_cycles_c = 16;
  localparam int settle_c       = reset_depth_c + 4;
  localparam int latency_c      = num_tiles_c + 2;

  // run length in cycles with one drain of the pipe per test
  localparam int drain_c       = latency_c + 4;
  localparam int random_reqs_c = 200;
  localparam int test_cycles_c = (num_tiles_c * dmem_words_c) + (num_tiles_c * 8) + 9 + 6 +
                                 random_reqs_c + 6 * drain_c;
  localparam int timeout_c     = 2 * test_cycles_c + reset_cycles_c + settle_c;

  typedef struct packed {
    mc_pkg::rsp_pkt_t rsp;
    int               due;
  } exp_t;

  logic             clk_i;
  logic             rst_n_i;
  logic             req_valid_i;
  mc_pkg::req_pkt_t req_i;
  logic             err_o;
  logic             rsp_valid_o;
  mc_pkg::rsp_pkt_t rsp_o;
  mc_pkg::count_t   rsp_count_o;

  // reference model state
  mc_pkg::data_t  model_mem [num_tiles_c][dmem_words_c];
  mc_pkg::tag_t   model_tag;
  mc_pkg::count_t model_count;

  exp_t exp_q [$];
  int   err_due_q [$];

  int cycle       = 0;
  int check_count = 0;
  int error_count = 0;
  int test_base   = 0;
  bit checking    = 1'b0;

  mc_row #(
    .num_tiles_p  (num_tiles_c),
    .dmem_words_p (dmem_words_c),
    .reset_depth_p(reset_depth_c)
  ) uut (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_valid_i(req_valid_i),
    .req_i      (req_i),
    .err_o      (err_o),
    .rsp_valid_o(rsp_valid_o),
    .rsp_o      (rsp_o),
    .rsp_count_o(rsp_count_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
  end

  initial begin
    wait (cycle >= timeout_c);
    $display("timeout: the run did not finish within %0d cycles", timeout_c);
    $display("sim failed");
    $finish;
  end

  // predicts the response of one accepted request and updates the model memory and tag
  function automatic bit predict_rsp(input mc_pkg::req_pkt_t req,
                                     output mc_pkg::rsp_pkt_t rsp);
    int            idx;
    mc_pkg::data_t old;
    bit            has_rsp;
    idx      = int'(req.addr) % dmem_words_c;
    old      = model_mem[req.dest][idx];
    rsp.src  = req.dest;
    rsp.tag  = model_tag;
    rsp.data = old;
    has_rsp  = 1'b0;
    model_tag = model_tag + 1'b1;
    case (req.op)
      mc_pkg::op_store: begin
        model_mem[req.dest][idx] = req.data;
      end
      mc_pkg::op_load: begin
        has_rsp = 1'b1;
      end
      mc_pkg::op_add: begin
        model_mem[req.dest][idx] = old + req.data;
        has_rsp = 1'b1;
      end
      default: begin
        has_rsp = 1'b0;
      end
    endcase
    if (has_rsp) begin
      model_count = model_count + 1'b1;
    end
    return has_rsp;
  endfunction

  task automatic compare_rsp(input mc_pkg::rsp_pkt_t got, input mc_pkg::rsp_pkt_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR %0t: response src/tag/data got %0d/%02h/%08h, expected %0d/%02h/%08h",
               $time, got.src, got.tag, got.data, exp.src, exp.tag, exp.data);
    end
  endtask

  task automatic compare_count(input mc_pkg::count_t got, input mc_pkg::count_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR %0t: response count got %0d, expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_err(input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR %0t: err_o got %b, expected %b", $time, got, exp);
    end
  endtask

  // drives one request on the next falling edge and records what it should cause
  task automatic send_req(input mc_pkg::op_t op, input int dest, input int addr,
                          input mc_pkg::data_t data);
    mc_pkg::req_pkt_t req;
    mc_pkg::rsp_pkt_t rsp;
    exp_t             e;
    req.op   = op;
    req.dest = mc_pkg::coord_t'(dest);
    req.addr = mc_pkg::addr_t'(addr);
    req.data = data;
    // the injector replaces this tag
    req.tag  = mc_pkg::tag_t'($urandom());
    @(negedge clk_i);
    req_valid_i = 1'b1;
    req_i       = req;
    if (dest >= num_tiles_c) begin
      err_due_q.push_back(cycle + 1);
    end else if (predict_rsp(req, rsp)) begin
      e.rsp = rsp;
      e.due = cycle + latency_c;
      exp_q.push_back(e);
    end
  endtask

  task automatic drain_pipe();
    @(negedge clk_i);
    req_valid_i = 1'b0;
    while (exp_q.size() > 0 || err_due_q.size() > 0) begin
      @(negedge clk_i);
    end
    repeat (2) @(negedge clk_i);
  endtask

  task automatic report_test(input int num, input string name);
    $display("test %0d %s: %0d errors", num, name, error_count - test_base);
    test_base = error_count;
  endtask

  // response and err_o checker
  initial begin
    exp_t e;
    bit   err_exp;
    wait (checking);
    forever begin
      @(negedge clk_i);
      while (exp_q.size() > 0 && exp_q[0].due < cycle) begin
        e = exp_q.pop_front();
        error_count++;
        $display("missing response: tag %02h from tile %0d was due in cycle %0d and never came",
                 e.rsp.tag, e.rsp.src, e.due);
      end
      if (rsp_valid_o === 1'b1) begin
        if (exp_q.size() == 0) begin
          error_count++;
          $display("unexpected response in cycle %0d: tag %02h from tile %0d was not expected",
                   cycle, rsp_o.tag, rsp_o.src);
        end else begin
          e = exp_q.pop_front();
          if (e.due != cycle) begin
            error_count++;
            $display("response with tag %02h came in cycle %0d but was due in cycle %0d",
                     rsp_o.tag, cycle, e.due);
          end
          compare_rsp(rsp_o, e.rsp);
        end
      end
      err_exp = (err_due_q.size() > 0) && (err_due_q[0] == cycle);
      if (err_exp) begin
        void'(err_due_q.pop_front());
      end
      check_err(err_o, err_exp);
    end
  end

  initial begin
    int          addr_list [4];
    mc_pkg::op_t rand_op;
    void'($urandom(32'hda00));
    rst_n_i     = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    model_tag   = '0;
    model_count = '0;
    for (int t = 0; t < num_tiles_c; t++) begin
      for (int a = 0; a < dmem_words_c; a++) begin
        model_mem[t][a] = '0;
      end
    end
    repeat (reset_cycles_c) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    repeat (settle_c) @(negedge clk_i);
    checking = 1'b1;

    // every word of every tile reads zero after reset
    for (int t = 0; t < num_tiles_c; t++) begin
      for (int a = 0; a < dmem_words_c; a++) begin
        send_req(mc_pkg::op_load, t, a, $urandom());
      end
    end
    drain_pipe();
    report_test(1, "loads after reset");

    // stores then loads with addresses that wrap past the memory size
    for (int t = 0; t < num_tiles_c; t++) begin
      for (int i = 0; i < 4; i++) begin
        addr_list[i] = $urandom_range(255, 0);
        send_req(mc_pkg::op_store, t, addr_list[i], $urandom());
      end
      for (int i = 0; i < 4; i++) begin
        send_req(mc_pkg::op_load, t, addr_list[i], $urandom());
      end
    end
    drain_pipe();
    report_test(2, "store then load");

    // back to back fetch-and-add on one word
    for (int i = 0; i < 8; i++) begin
      send_req(mc_pkg::op_add, 2, 5, $urandom_range(1000, 1));
    end
    send_req(mc_pkg::op_load, 2, 5, $urandom());
    drain_pipe();
    report_test(3, "fetch-and-add chain");

    // loads between the dropped requests show that the tag holds
    send_req(mc_pkg::op_load, num_tiles_c, 0, $urandom());
    send_req(mc_pkg::op_load, 1, 3, $urandom());
    send_req(mc_pkg::op_add, 15, 7, $urandom());
    send_req(mc_pkg::op_store, $urandom_range(15, num_tiles_c), 1, $urandom());
    send_req(mc_pkg::op_load, 3, 9, $urandom());
    send_req(mc_pkg::op_load, 9, 2, $urandom());
    drain_pipe();
    report_test(4, "bad destination");

    // random traffic with one request every cycle
    for (int i = 0; i < random_reqs_c; i++) begin
      case ($urandom_range(2, 0))
        0:       rand_op = mc_pkg::op_store;
        1:       rand_op = mc_pkg::op_load;
        default: rand_op = mc_pkg::op_add;
      endcase
      send_req(rand_op, $urandom_range(num_tiles_c - 1, 0), $urandom_range(255, 0), $urandom());
    end
    drain_pipe();
    report_test(5, "random traffic");

    compare_count(rsp_count_o, model_count);
    report_test(6, "response count");

    $display("summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: verilog/mc_row.sv
/*
  One row of tiles between an injector and a collector.
  Response latency is num_tiles_p+2 cycles; num_tiles_p ranges from 1 to 16.
*/
`timescale 1ns/100ps

module mc_row #(
  parameter int num_tiles_p   = 4,
  parameter int dmem_words_p  = 16,
  parameter int reset_depth_p = 3
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             req_valid_i,
  input  mc_pkg::req_pkt_t req_i,
  output logic             err_o,
  output logic             rsp_valid_o,
  output mc_pkg::rsp_pkt_t rsp_o,
  output mc_pkg::count_t   rsp_count_o
);

  logic rst_n_sync;

  // stage 0 is the injector output or the empty response, stage k+1 is tile k
  logic [num_tiles_p:0]                   req_valid;
  mc_pkg::req_pkt_t [num_tiles_p:0] req_chain;
  logic [num_tiles_p:0]                   rsp_valid;
  mc_pkg::rsp_pkt_t [num_tiles_p:0] rsp_chain;

  mc_reset_sync #(
    .reset_depth_p(reset_depth_p)
  ) reset_sync (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .rst_n_o(rst_n_sync)
  );

  mc_injector #(
    .num_tiles_p(num_tiles_p)
  ) injector (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_sync),
    .req_valid_i(req_valid_i),
    .req_i      (req_i),
    .req_valid_o(req_valid[0]),
    .req_o      (req_chain[0]),
    .err_o      (err_o)
  );

  // nothing enters the response chain west of tile 0
  assign rsp_valid[0] = 1'b0;
  assign rsp_chain[0] = '0;

  for (genvar i = 0; i < num_tiles_p; i++) begin : tile_gen
    mc_tile #(
      .my_x_p      (mc_pkg::coord_t'(i)),
      .dmem_words_p(dmem_words_p)
    ) tile (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_sync),
      .req_valid_i(req_valid[i]),
      .req_i      (req_chain[i]),
      .req_valid_o(req_valid[i+1]),
      .req_o      (req_chain[i+1]),
      .rsp_valid_i(rsp_valid[i]),
      .rsp_i      (rsp_chain[i]),
      .rsp_valid_o(rsp_valid[i+1]),
      .rsp_o      (rsp_chain[i+1])
    );
  end

  mc_collector collector (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_sync),
    .rsp_valid_i(rsp_valid[num_tiles_p]),
    .rsp_i      (rsp_chain[num_tiles_p]),
    .rsp_valid_o(rsp_valid_o),
    .rsp_o      (rsp_o),
    .rsp_count_o(rsp_count_o)
  );

endmodule

// File: verilog/mc_collector.sv
/*
  Last response stage; drives the external port as a one-cycle strobe.
  rsp_count_o wraps at 16 bits.
*/
`timescale 1ns/100ps

module mc_collector (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             rsp_valid_i,
  input  mc_pkg::rsp_pkt_t rsp_i,
  output logic             rsp_valid_o,
  output mc_pkg::rsp_pkt_t rsp_o,
  output mc_pkg::count_t   rsp_count_o
);

  logic             rsp_valid_r;
  mc_pkg::rsp_pkt_t rsp_r;
  mc_pkg::count_t   count_r;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_r <= 1'b0;
      count_r     <= '0;
    end else begin
      rsp_valid_r <= rsp_valid_i;
      // count moves on the same edge as the strobe
      if (rsp_valid_i) begin
        count_r <= count_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp_valid_i) begin
      rsp_r <= rsp_i;
    end
  end

  assign rsp_valid_o = rsp_valid_r;
  assign rsp_o       = rsp_r;
  assign rsp_count_o = count_r;

endmodule

// File: verilog/mc_tile.sv
/*
  One tile: data memory plus a request hop and a response hop, one cycle each.
  dmem_words_p must be a power of two up to 256; addresses wrap modulo its size.
*/
`timescale 1ns/100ps

module mc_tile #(
  parameter mc_pkg::coord_t my_x_p       = '0,
  parameter int             dmem_words_p = 16
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             req_valid_i,
  input  mc_pkg::req_pkt_t req_i,
  output logic             req_valid_o,
  output mc_pkg::req_pkt_t req_o,
  input  logic             rsp_valid_i,
  input  mc_pkg::rsp_pkt_t rsp_i,
  output logic             rsp_valid_o,
  output mc_pkg::rsp_pkt_t rsp_o
);

  localparam int idx_w_lp = (dmem_words_p > 1) ? $clog2(dmem_words_p) : 1;

  mc_pkg::data_t    dmem_r [dmem_words_p];
  logic [idx_w_lp-1:0] word_idx;
  logic             hit;
  logic             is_load;
  logic             is_add;
  logic             own_rsp;
  mc_pkg::data_t    old_word;
  mc_pkg::data_t    sum_word;
  mc_pkg::rsp_pkt_t own_pkt;
  logic             req_valid_r;
  mc_pkg::req_pkt_t req_r;
  logic             rsp_valid_r;
  mc_pkg::rsp_pkt_t rsp_r;

  assign hit      = req_valid_i && (req_i.dest == my_x_p);
  assign is_load  = req_i.op == mc_pkg::op_load;
  assign is_add   = req_i.op == mc_pkg::op_add;
  assign own_rsp  = hit && (is_load || is_add);
  assign word_idx = idx_w_lp'(req_i.addr % dmem_words_p);

  // asynchronous read so that an add updates the word in the same cycle
  assign old_word = dmem_r[word_idx];
  assign sum_word = old_word + req_i.data;

  always_comb begin
    own_pkt.src  = my_x_p;
    own_pkt.tag  = req_i.tag;
    own_pkt.data = old_word;
  end

  // data memory, cleared to zero on reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < dmem_words_p; i++) begin
        dmem_r[i] <= '0;
      end
    end else if (hit) begin
      if (req_i.op == mc_pkg::op_store) begin
        dmem_r[word_idx] <= req_i.data;
      end else if (is_add) begin
        dmem_r[word_idx] <= sum_word;
      end
    end
  end

  // hop valids
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_valid_r <= 1'b0;
      rsp_valid_r <= 1'b0;
    end else begin
      req_valid_r <= req_valid_i && !hit;
      // fixed latency keeps own_rsp and rsp_valid_i apart
      rsp_valid_r <= own_rsp || rsp_valid_i;
    end
  end

  // hop payloads
  always_ff @(posedge clk_i) begin
    if (req_valid_i && !hit) begin
      req_r <= req_i;
    end
    if (own_rsp) begin
      rsp_r <= own_pkt;
    end else if (rsp_valid_i) begin
      rsp_r <= rsp_i;
    end
  end

  assign req_valid_o = req_valid_r;
  assign req_o       = req_r;
  assign rsp_valid_o = rsp_valid_r;
  assign rsp_o       = rsp_r;

endmodule

// File: verilog/mc_injector.sv
/*
  Entry stage of the request chain. No back-pressure: one request per cycle at most.
  Requests to a tile at or above num_tiles_p are dropped and flagged on err_o.
*/
`timescale 1ns/100ps

module mc_injector #(
  parameter int num_tiles_p = 4
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             req_valid_i,
  input  mc_pkg::req_pkt_t req_i,
  output logic             req_valid_o,
  output mc_pkg::req_pkt_t req_o,
  output logic             err_o
);

  logic             dest_ok;
  logic             accept;
  mc_pkg::tag_t     tag_r;
  mc_pkg::req_pkt_t stamped;
  mc_pkg::req_pkt_t req_r;
  logic             req_valid_r;
  logic             err_r;

  assign dest_ok = int'(req_i.dest) < num_tiles_p;
  assign accept  = req_valid_i && dest_ok;

  // incoming tag field is ignored and replaced by the sequence tag
  always_comb begin
    stamped     = req_i;
    stamped.tag = tag_r;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_valid_r <= 1'b0;
      err_r       <= 1'b0;
      tag_r       <= '0;
    end else begin
      req_valid_r <= accept;
      err_r       <= req_valid_i && !dest_ok;
      // tag wraps, dropped requests do not consume one
      if (accept) begin
        tag_r <= tag_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_r <= stamped;
    end
  end

  assign req_valid_o = req_valid_r;
  assign req_o       = req_r;
  assign err_o       = err_r;

endmodule

// File: verilog/mc_reset_sync.sv
/*
  Reset pipeline: asserts asynchronously, releases after reset_depth_p edges.
  reset_depth_p must be at least 1.
*/
`timescale 1ns/100ps

module mc_reset_sync #(
  parameter int reset_depth_p = 3
) (
  input  logic clk_i,
  input  logic rst_n_i,
  output logic rst_n_o
);

  logic [reset_depth_p-1:0] sync_r;

  // ones shift in from the bottom once the external reset lets go
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_r <= '0;
    end else begin
      sync_r <= reset_depth_p'({sync_r, 1'b1});
    end
  end

  assign rst_n_o = sync_r[reset_depth_p-1];

endmodule

// File: verilog/mc_pkg.sv
/*
  Shared widths, operation codes and packet formats for the memory row.
  coord_t limits the row to 16 tiles; addr_t allows at most 256 words per tile.
*/
package mc_pkg;

  // field widths
  localparam int data_w_c  = 32;
  localparam int addr_w_c  = 8;
  localparam int coord_w_c = 4;
  localparam int tag_w_c   = 8;
  localparam int op_w_c    = 2;
  localparam int count_w_c = 16;

  typedef logic [data_w_c-1:0]  data_t;
  typedef logic [addr_w_c-1:0]  addr_t;
  typedef logic [coord_w_c-1:0] coord_t;
  typedef logic [tag_w_c-1:0]   tag_t;
  typedef logic [op_w_c-1:0]    op_t;
  typedef logic [count_w_c-1:0] count_t;

  // operation codes, the fourth code is consumed with no effect
  localparam op_t op_store = 2'd0;
  localparam op_t op_load  = 2'd1;
  localparam op_t op_add   = 2'd2;

  // request travelling east on the request chain
  typedef struct packed {
    op_t    op;
    coord_t dest;
    addr_t  addr;
    data_t  data;
    tag_t   tag;
  } req_pkt_t;

  // response travelling east on the response chain
  typedef struct packed {
    coord_t src;
    tag_t   tag;
    data_t  data;
  } rsp_pkt_t;

endpackage
